/* Bender.yml */
package:
  name: controlUnit

sources:
  - logic/controlPkg.sv
  - logic/instructionDecoder.sv
  - logic/phaseSequencer.sv
  - logic/controlWordEncoder.sv
  - logic/controlUnit.sv
  - target: test
    files:
      - verification/controlUnitTb.sv

/* build.f */
logic/controlPkg.sv
logic/instructionDecoder.sv
logic/phaseSequencer.sv
logic/controlWordEncoder.sv
logic/controlUnit.sv
verification/controlUnitTb.sv

/* logic/controlPkg.sv */
`default_nettype none

package controlPkg;

    // Field and select widths
    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int aluOpWidth = 3;
    localparam int stepWidth = 3;
    localparam int causeWidth = 2;
    localparam int pcSourceWidth = 2;
    localparam int addressSourceWidth = 3;
    localparam int dataSourceWidth = 3;
    localparam int regDestWidth = 2;
    localparam int aluSourceWidth = 2;

    typedef logic [opcodeWidth-1:0] opcodeT;
    typedef logic [functWidth-1:0] functT;
    typedef logic [aluOpWidth-1:0] aluOpT;
    typedef logic [stepWidth-1:0] stepT;
    typedef logic [causeWidth-1:0] causeT;
    typedef logic [pcSourceWidth-1:0] pcSourceT;
    typedef logic [addressSourceWidth-1:0] addressSourceT;
    typedef logic [dataSourceWidth-1:0] dataSourceT;
    typedef logic [regDestWidth-1:0] regDestT;
    typedef logic [aluSourceWidth-1:0] aluSourceT;

    // One phase per instruction class, plus the shared fetch and exception phases
    typedef enum logic [2:0] {
        phaseFetch,
        phaseAdd,
        phaseSub,
        phaseAddm,
        phaseBreak,
        phaseRte,
        phaseException
    } phaseT;

    // Instruction encodings
    localparam opcodeT opcodeRType = 6'd0;
    localparam opcodeT opcodeAddm = 6'd1;

    localparam functT functAdd = 6'd32;
    localparam functT functSub = 6'd34;
    localparam functT functBreak = 6'd13;
    localparam functT functRte = 6'd19;

    // ALU operations
    localparam aluOpT aluOpAdd = 3'd1;
    localparam aluOpT aluOpSub = 3'd2;

    // Exception causes as seen by the datapath
    localparam causeT causeUnknown = 2'd0;
    localparam causeT causeOverflow = 2'd1;

    // PC source mux
    localparam pcSourceT pcSourceAlu = 2'd1;
    localparam pcSourceT pcSourceVector = 2'd2;
    localparam pcSourceT pcSourceEpc = 2'd3;

    // Memory address mux where zero selects the PC
    localparam addressSourceT addressSourceAluOut = 3'd4;

    // Register file write data mux
    localparam dataSourceT dataSourceAluOut = 3'd4;
    localparam dataSourceT dataSourceAddm = 3'd6;

    // Destination register mux
    localparam regDestT regDestRd = 2'd3;
    localparam regDestT regDestRt = 2'd1;

    // ALU operand A mux
    localparam aluSourceT aluSourcePc = 2'd1;
    localparam aluSourceT aluSourceRegA = 2'd2;
    localparam aluSourceT aluSourceMdr = 2'd3;

    // ALU operand B mux
    localparam aluSourceT aluSourceFour = 2'd1;
    localparam aluSourceT aluSourceRegB = 2'd2;
    localparam aluSourceT aluSourceZero = 2'd0;

    // Fetch timing
    localparam stepT fetchIrStep = 3'd3;
    localparam stepT fetchOperandStep = 3'd4;
    localparam stepT fetchDecodeStep = 3'd6;

    // Last step of each execute phase
    localparam stepT aluLastStep = 3'd2;
    localparam stepT addmLastStep = 3'd6;
    localparam stepT shortLastStep = 3'd1;

endpackage

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit import controlPkg::*; (
    input wire clock,
    input wire reset,
    input wire opcodeT opcode,
    input wire functT funct,
    input wire overflow,
    output logic writeMem,
    output logic irWrite,
    output logic regWrite,
    output logic pcWrite,
    output logic regAWrite,
    output logic regBWrite,
    output logic aluOutWrite,
    output logic mdrWrite,
    output logic epcWrite,
    output aluOpT aluOp,
    output causeT exceptionCause,
    output pcSourceT pcSource,
    output addressSourceT addressSource,
    output regDestT regDest,
    output dataSourceT dataSource,
    output aluSourceT aluSourceA,
    output aluSourceT aluSourceB
);

    phaseT decodedPhase;
    causeT decodedCause;
    phaseT phase;
    stepT step;
    causeT cause;

    instructionDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .decodedPhase(decodedPhase),
        .decodedCause(decodedCause)
    );

    phaseSequencer sequencer (
        .clock(clock),
        .reset(reset),
        .decodedPhase(decodedPhase),
        .decodedCause(decodedCause),
        .overflow(overflow),
        .phase(phase),
        .step(step),
        .cause(cause)
    );

    // Outputs follow the registered phase and step
    controlWordEncoder encoder (
        .phase(phase),
        .step(step),
        .cause(cause),
        .reset(reset),
        .writeMem(writeMem),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .pcWrite(pcWrite),
        .regAWrite(regAWrite),
        .regBWrite(regBWrite),
        .aluOutWrite(aluOutWrite),
        .mdrWrite(mdrWrite),
        .epcWrite(epcWrite),
        .aluOp(aluOp),
        .exceptionCause(exceptionCause),
        .pcSource(pcSource),
        .addressSource(addressSource),
        .regDest(regDest),
        .dataSource(dataSource),
        .aluSourceA(aluSourceA),
        .aluSourceB(aluSourceB)
    );

endmodule

`default_nettype wire

/* logic/controlWordEncoder.sv */
`timescale 1ns/1ns
`default_nettype none

module controlWordEncoder import controlPkg::*; (
    input wire phaseT phase,
    input wire stepT step,
    input wire causeT cause,
    input wire reset,
    output logic writeMem,
    output logic irWrite,
    output logic regWrite,
    output logic pcWrite,
    output logic regAWrite,
    output logic regBWrite,
    output logic aluOutWrite,
    output logic mdrWrite,
    output logic epcWrite,
    output aluOpT aluOp,
    output causeT exceptionCause,
    output pcSourceT pcSource,
    output addressSourceT addressSource,
    output regDestT regDest,
    output dataSourceT dataSource,
    output aluSourceT aluSourceA,
    output aluSourceT aluSourceB
);

    always_comb begin
        // Everything inactive unless the current step asks for it
        writeMem = 1'b0;
        irWrite = 1'b0;
        regWrite = 1'b0;
        pcWrite = 1'b0;
        regAWrite = 1'b0;
        regBWrite = 1'b0;
        aluOutWrite = 1'b0;
        mdrWrite = 1'b0;
        epcWrite = 1'b0;
        aluOp = '0;
        exceptionCause = '0;
        pcSource = '0;
        addressSource = '0;
        regDest = '0;
        dataSource = '0;
        aluSourceA = '0;
        aluSourceB = '0;

        if (!reset) begin
            case (phase)
                phaseFetch: begin
                    if (step <= fetchIrStep) begin
                        // Memory read at PC while the ALU computes PC + 4
                        aluOp = aluOpAdd;
                        aluSourceA = aluSourcePc;
                        aluSourceB = aluSourceFour;
                        pcSource = pcSourceAlu;
                        irWrite = (step == fetchIrStep);
                        pcWrite = (step == fetchIrStep);
                    end else if (step == fetchOperandStep) begin
                        aluOp = aluOpAdd;
                        regAWrite = 1'b1;
                        regBWrite = 1'b1;
                        aluOutWrite = 1'b1;
                    end
                end

                phaseAdd, phaseSub: begin
                    if (step == 3'd0) begin
                        aluOp = (phase == phaseSub) ? aluOpSub : aluOpAdd;
                        aluSourceA = aluSourceRegA;
                        aluSourceB = aluSourceRegB;
                        aluOutWrite = 1'b1;
                    end else if (step == 3'd1) begin
                        regWrite = 1'b1;
                        regDest = regDestRd;
                        dataSource = dataSourceAluOut;
                    end
                end

                phaseBreak: begin
                    // Rewind the PC to the break instruction itself
                    if (step == 3'd0) begin
                        pcWrite = 1'b1;
                        pcSource = pcSourceAlu;
                        aluOp = aluOpSub;
                        aluSourceA = aluSourcePc;
                        aluSourceB = aluSourceFour;
                    end
                end

                phaseRte: begin
                    if (step == 3'd0) begin
                        pcWrite = 1'b1;
                        pcSource = pcSourceEpc;
                    end
                end

                phaseAddm: begin
                    case (step)
                        3'd0: begin
                            // Address is register A plus zero
                            aluOp = aluOpAdd;
                            aluSourceA = aluSourceRegA;
                            aluSourceB = aluSourceZero;
                            aluOutWrite = 1'b1;
                        end

                        3'd1, 3'd2: begin
                            addressSource = addressSourceAluOut;
                        end

                        3'd3: begin
                            mdrWrite = 1'b1;
                        end

                        3'd4: begin
                            aluOp = aluOpAdd;
                            aluSourceA = aluSourceMdr;
                            aluSourceB = aluSourceRegB;
                            aluOutWrite = 1'b1;
                        end

                        3'd5: begin
                            regWrite = 1'b1;
                            regDest = regDestRt;
                            dataSource = dataSourceAddm;
                        end

                        default: begin
                        end
                    endcase
                end

                phaseException: begin
                    if (step == 3'd0) begin
                        epcWrite = 1'b1;
                        pcWrite = 1'b1;
                        pcSource = pcSourceVector;
                        exceptionCause = cause;
                    end
                end

                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/instructionDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instructionDecoder import controlPkg::*; (
    input wire opcodeT opcode,
    input wire functT funct,
    output phaseT decodedPhase,
    output causeT decodedCause
);

    // Anything not listed below traps as an unknown instruction
    always_comb begin
        decodedPhase = phaseException;
        decodedCause = causeUnknown;

        case (opcode)
            opcodeRType: begin
                // For R-type the funct field picks the operation
                case (funct)
                    functAdd: begin
                        decodedPhase = phaseAdd;
                    end

                    functSub: begin
                        decodedPhase = phaseSub;
                    end

                    functBreak: begin
                        decodedPhase = phaseBreak;
                    end

                    functRte: begin
                        decodedPhase = phaseRte;
                    end

                    default: begin
                        decodedPhase = phaseException;
                    end
                endcase
            end

            opcodeAddm: begin
                decodedPhase = phaseAddm;
            end

            default: begin
                decodedPhase = phaseException;
            end
        endcase
    end

    // The cause only matters when the decoded phase is the exception phase
    //   so the default value is left on every legal instruction

endmodule

`default_nettype wire

/* logic/phaseSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module phaseSequencer import controlPkg::*; (
    input wire clock,
    input wire reset,
    input wire phaseT decodedPhase,
    input wire causeT decodedCause,
    input wire overflow,
    output phaseT phase,
    output stepT step,
    output causeT cause
);

    logic aluPhase;
    logic atLastStep;
    logic decodeNow;
    logic overflowTrap;

    // Final step index of each phase
    function automatic stepT lastStep(input phaseT p);
        case (p)
            phaseFetch: begin
                return fetchDecodeStep;
            end

            phaseAdd, phaseSub: begin
                return aluLastStep;
            end

            phaseAddm: begin
                return addmLastStep;
            end

            default: begin
                return shortLastStep;
            end
        endcase
    endfunction

    assign aluPhase = (phase == phaseAdd) || (phase == phaseSub);
    assign atLastStep = (step == lastStep(phase));
    assign decodeNow = (phase == phaseFetch) && (step == fetchDecodeStep);

    // Overflow is sampled in the cycle the ALU result is latched
    assign overflowTrap = aluPhase && (step == '0) && overflow;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= phaseFetch;
            step <= '0;
            cause <= causeUnknown;
        end else if (decodeNow) begin
            phase <= decodedPhase;
            step <= '0;
            cause <= decodedCause;
        end else if (overflowTrap) begin
            // Abort before the register write in step 1
            phase <= phaseException;
            step <= '0;
            cause <= causeOverflow;
        end else if (atLastStep) begin
            phase <= phaseFetch;
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    // Step counter stays inside the current phase
    stepInRange: assert property (
        @(posedge clock) disable iff (reset)
        step <= lastStep(phase)
    ) else $error("step %0d beyond last step of phase %s", step, phase.name());

    // Fetch can only be left through the decode step
    fetchExitAtDecode: assert property (
        @(posedge clock) disable iff (reset)
        (phase == phaseFetch && step != fetchDecodeStep) |=> (phase == phaseFetch)
    ) else $error("fetch left before the decode step");

endmodule

`default_nettype wire

/* verification/controlUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb import controlPkg::*; ();

    localparam int resetCycles = 3;
    localparam int directedCount = 9;
    localparam int instructionTotal = 300;
    // Longest instruction is addm with seven fetch steps plus seven execute steps
    localparam int maxInstructionCycles = 14;
    localparam int cycleLimit = instructionTotal * maxInstructionCycles + 20;
    localparam logic [31:0] randomSeed = 32'hb7d6_fa7a;

    localparam int overflowLow = 0;
    localparam int overflowHigh = 1;
    localparam int overflowRandom = 2;

    // Reference model's own view of the instruction phases
    typedef enum int {kindFetch, kindAdd, kindSub, kindAddm, kindBreak, kindRte, kindTrap} kindT;

    logic clock = 1'b0;
    logic reset;
    opcodeT opcode;
    functT funct;
    logic overflow;
    logic writeMem, irWrite, regWrite, pcWrite, regAWrite, regBWrite;
    logic aluOutWrite, mdrWrite, epcWrite;
    aluOpT aluOp;
    causeT exceptionCause;
    pcSourceT pcSource;
    addressSourceT addressSource;
    regDestT regDest;
    dataSourceT dataSource;
    aluSourceT aluSourceA, aluSourceB;

    kindT modelKind;
    int modelStep;
    causeT modelCause;
    logic [8:0] expEnables;
    logic [18:0] expSelects;
    logic [8:0] dutEnables;
    logic [18:0] dutSelects;
    int errorCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int cycleCount = 0;

    controlUnit dut (
        .clock(clock), .reset(reset), .opcode(opcode), .funct(funct), .overflow(overflow),
        .writeMem(writeMem), .irWrite(irWrite), .regWrite(regWrite), .pcWrite(pcWrite),
        .regAWrite(regAWrite), .regBWrite(regBWrite), .aluOutWrite(aluOutWrite),
        .mdrWrite(mdrWrite), .epcWrite(epcWrite), .aluOp(aluOp),
        .exceptionCause(exceptionCause), .pcSource(pcSource), .addressSource(addressSource),
        .regDest(regDest), .dataSource(dataSource), .aluSourceA(aluSourceA),
        .aluSourceB(aluSourceB)
    );

    always #50 clock = ~clock;

    assign dutEnables = {writeMem, irWrite, regWrite, pcWrite, regAWrite, regBWrite,
        aluOutWrite, mdrWrite, epcWrite};
    assign dutSelects = {aluOp, exceptionCause, pcSource, addressSource, regDest, dataSource,
        aluSourceA, aluSourceB};

    function automatic kindT decodeKind(input opcodeT op, input functT fn);
        if (op == opcodeAddm) begin
            return kindAddm;
        end
        if (op != opcodeRType) begin
            return kindTrap;
        end
        if (fn == functAdd) return kindAdd;
        if (fn == functSub) return kindSub;
        if (fn == functBreak) return kindBreak;
        if (fn == functRte) return kindRte;
        return kindTrap;
    endfunction

    // Number of cycles spent in each phase
    function automatic int kindLength(input kindT kind);
        case (kind)
            kindFetch, kindAddm: return 7;
            kindAdd, kindSub: return 3;
            default: return 2;
        endcase
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            modelKind <= kindFetch;
            modelStep <= 0;
            modelCause <= causeUnknown;
        end else if (modelKind == kindFetch && modelStep == 6) begin
            modelKind <= decodeKind(opcode, funct);
            modelStep <= 0;
            modelCause <= causeUnknown;
        end else if ((modelKind == kindAdd || modelKind == kindSub) && modelStep == 0
                && overflow) begin
            modelKind <= kindTrap;
            modelStep <= 0;
            modelCause <= causeOverflow;
        end else if (modelStep == kindLength(modelKind) - 1) begin
            modelKind <= kindFetch;
            modelStep <= 0;
        end else begin
            modelStep <= modelStep + 1;
        end
    end

    // Expected control word for the model's current phase and step
    always_comb begin
        logic wMem, wIr, wReg, wPc, wA, wB, wOut, wMdr, wEpc;
        aluOpT op;
        causeT cse;
        pcSourceT pcs;
        addressSourceT adr;
        regDestT dst;
        dataSourceT dat;
        aluSourceT srcA, srcB;
        {wMem, wIr, wReg, wPc, wA, wB, wOut, wMdr, wEpc} = '0;
        {op, cse, pcs, adr, dst, dat, srcA, srcB} = '0;
        if (!reset) begin
            case (modelKind)
                kindFetch: begin
                    if (modelStep <= 3) begin
                        {op, srcA, srcB, pcs} = {aluOpAdd, aluSourcePc, aluSourceFour, pcSourceAlu};
                        wIr = (modelStep == 3);
                        wPc = (modelStep == 3);
                    end else if (modelStep == 4) begin
                        {wA, wB, wOut, op} = {3'b111, aluOpAdd};
                    end
                end
                kindAdd, kindSub: begin
                    if (modelStep == 0) begin
                        op = (modelKind == kindAdd) ? aluOpAdd : aluOpSub;
                        {srcA, srcB, wOut} = {aluSourceRegA, aluSourceRegB, 1'b1};
                    end else if (modelStep == 1) begin
                        {wReg, dst, dat} = {1'b1, regDestRd, dataSourceAluOut};
                    end
                end
                kindBreak: begin
                    if (modelStep == 0) begin
                        {wPc, pcs, op} = {1'b1, pcSourceAlu, aluOpSub};
                        {srcA, srcB} = {aluSourcePc, aluSourceFour};
                    end
                end
                kindRte: begin
                    if (modelStep == 0) {wPc, pcs} = {1'b1, pcSourceEpc};
                end
                kindAddm: begin
                    case (modelStep)
                        0: {op, srcA, srcB, wOut} = {aluOpAdd, aluSourceRegA, aluSourceZero, 1'b1};
                        1, 2: adr = addressSourceAluOut;
                        3: wMdr = 1'b1;
                        4: {op, srcA, srcB, wOut} = {aluOpAdd, aluSourceMdr, aluSourceRegB, 1'b1};
                        5: {wReg, dst, dat} = {1'b1, regDestRt, dataSourceAddm};
                        default: ;
                    endcase
                end
                kindTrap: begin
                    if (modelStep == 0) {wEpc, wPc, pcs, cse} = {2'b11, pcSourceVector, modelCause};
                end
                default: ;
            endcase
        end
        expEnables = {wMem, wIr, wReg, wPc, wA, wB, wOut, wMdr, wEpc};
        expSelects = {op, cse, pcs, adr, dst, dat, srcA, srcB};
    end

    enablesMatch: assert property (@(posedge clock) dutEnables == expEnables)
        else begin
            errorCount++;
            $display("Fail at %0t ns: write enables %b, expected %b (phase %0d step %0d)",
                $time, $sampled(dutEnables), $sampled(expEnables), $sampled(modelKind),
                $sampled(modelStep));
        end

    selectsMatch: assert property (@(posedge clock) dutSelects == expSelects)
        else begin
            errorCount++;
            $display("Fail at %0t ns: selects %h, expected %h (phase %0d step %0d)",
                $time, $sampled(dutSelects), $sampled(expSelects), $sampled(modelKind),
                $sampled(modelStep));
        end

    resetQuiet: assert property (@(posedge clock) reset |-> (dutEnables == '0 && dutSelects == '0))
        else begin
            errorCount++;
            $display("Fail at %0t ns: control outputs active during reset", $time);
        end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic driveOverflow(input int mode);
        if (mode == overflowRandom) overflow <= 1'($urandom_range(0, 1));
        else overflow <= (mode == overflowHigh);
    endtask

    // Issue one instruction at fetch step 0 and wait for its last execute step
    task automatic runInstruction(input opcodeT op, input functT fn, input int mode);
        opcode <= op;
        funct <= fn;
        driveOverflow(mode);
        do begin
            @(posedge clock);
            driveOverflow(mode);
        end while (!(modelKind != kindFetch && modelStep == kindLength(modelKind) - 1));
    endtask

    task automatic pickInstruction(output opcodeT op, output functT fn);
        int choice;
        choice = $urandom_range(0, 5);
        op = opcodeRType;
        fn = functT'($urandom());
        case (choice)
            0: fn = functAdd;
            1: fn = functSub;
            2: fn = functBreak;
            3: fn = functRte;
            4: op = opcodeAddm;
            default: begin
                if ($urandom_range(0, 1) == 1) begin
                    while (decodeKind(op, fn) != kindTrap) fn = functT'($urandom());
                end else begin
                    op = opcodeT'($urandom_range(2, 63));
                end
            end
        endcase
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("Test %s: passed", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        int errorsBefore;
        opcodeT op;
        functT fn;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        void'($urandom(randomSeed));

        errorsBefore = errorCount;
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b0;
        runInstruction(opcodeRType, functAdd, overflowLow);
        reportTest("reset and first fetch", errorsBefore);

        errorsBefore = errorCount;
        runInstruction(opcodeRType, functSub, overflowLow);
        runInstruction(opcodeRType, functBreak, overflowLow);
        runInstruction(opcodeRType, functRte, overflowLow);
        runInstruction(opcodeAddm, 6'd0, overflowLow);
        runInstruction(opcodeRType, 6'd63, overflowLow);
        runInstruction(6'd9, 6'd0, overflowLow);
        runInstruction(opcodeRType, functAdd, overflowHigh);
        runInstruction(opcodeRType, functSub, overflowHigh);
        reportTest("directed instructions", errorsBefore);

        errorsBefore = errorCount;
        repeat (instructionTotal - directedCount) begin
            pickInstruction(op, fn);
            runInstruction(op, fn, overflowRandom);
        end
        reportTest("random instructions", errorsBefore);

        $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
